/* rtl/radio_ctrl_cfg.svh */
//////////////////////////////
// Settings map of the control plane, one 32-bit word per address
// Timer occupies two words from its base, one-shot first
//////////////////////////////
`ifndef RADIO_CTRL_CFG_SVH
`define RADIO_CTRL_CFG_SVH

// Bus widths
`define SET_ADDR_W   8
`define SET_DATA_W   32
`define TICK_W       32
`define CTRL_BYTE_W  8

// Front-end control register addresses
`define SR_CLK       0
`define SR_SER       1
`define SR_ADC       2
`define SR_LED       3
`define SR_PHY       4
`define SR_LED_SRC   8

// Timer base, period word sits at base + 1
`define SR_SIMTIMER  198

`endif

/* rtl/radio_ctrl_pkg.sv */
//////////////////////////////
// Shared types of the control plane
// Widths come from the cfg header
//////////////////////////////
`default_nettype none

`include "radio_ctrl_cfg.svh"

package radio_ctrl_pkg;

   typedef logic [`SET_ADDR_W-1:0]  set_addr_t;
   typedef logic [`SET_DATA_W-1:0]  set_data_t;
   typedef logic [`CTRL_BYTE_W-1:0] ctrl_byte_t;

   // Timer count in dsp_clk cycles
   typedef logic [`TICK_W-1:0]      tick_t;

   typedef enum logic [1:0] {
      TIMER_IDLE,
      TIMER_ONESHOT,
      TIMER_PERIODIC
   } timer_state_e;

endpackage

`default_nettype wire

/* rtl/tick_counter.sv */
//////////////////////////////
// Expiry pulse N cycles after a load of N
// Loading 0 empties the counter
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tick_counter import radio_ctrl_pkg::*; (
   input  wire   dsp_clk,
   input  wire   wb_rst,
   input  logic  load_i,
   input  tick_t load_val_i,
   output logic  expire_o
);

   tick_t count;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         count    <= '0;
         expire_o <= 1'b0;
      end else if (load_i) begin
         // A load drops any expiry due at this edge
         count    <= load_val_i;
         expire_o <= 1'b0;
      end else if (count != '0) begin
         count    <= count - tick_t'(1);
         expire_o <= (count == tick_t'(1));
      end else begin
         expire_o <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* rtl/front_end_regs.sv */
//////////////////////////////
// Only the low data byte is stored; PHY keeps bit 0
// LED bits with source set follow hardware status
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "radio_ctrl_cfg.svh"

module front_end_regs import radio_ctrl_pkg::*; (
   input  wire        dsp_clk,
   input  wire        wb_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   output logic       clock_ready_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic       ser_enable_o,
   output logic       ser_prbsen_o,
   output logic       ser_loopen_o,
   output logic       ser_rx_en_o,
   output logic       adc_oe_a_o,
   output logic       adc_on_a_o,
   output logic       adc_oe_b_o,
   output logic       adc_on_b_o,
   output logic       phy_resetn_o,
   output ctrl_byte_t leds_o
);

   ctrl_byte_t clk_byte;
   ctrl_byte_t ser_byte;
   ctrl_byte_t adc_byte;
   ctrl_byte_t led_sw;
   ctrl_byte_t led_src;
   logic       phy_reset;
   ctrl_byte_t wr_byte;
   ctrl_byte_t led_hw;

   assign wr_byte = set_data_i[`CTRL_BYTE_W-1:0];

   //////////////////////////////
   // Register file, one byte per address
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clk_byte  <= '0;
         ser_byte  <= '0;
         adc_byte  <= '0;
         led_sw    <= '0;
         led_src   <= '0;
         phy_reset <= 1'b0;
      end else if (set_stb_i) begin
         case (set_addr_i)
            set_addr_t'(`SR_CLK):     clk_byte  <= wr_byte;
            set_addr_t'(`SR_SER):     ser_byte  <= wr_byte;
            set_addr_t'(`SR_ADC):     adc_byte  <= wr_byte;
            set_addr_t'(`SR_LED):     led_sw    <= wr_byte;
            set_addr_t'(`SR_PHY):     phy_reset <= wr_byte[0];
            set_addr_t'(`SR_LED_SRC): led_src   <= wr_byte;
            default: ;
         endcase
      end
   end

   //////////////////////////////
   // Field unpacking

   // Clock generator: ready, enables, selects
   assign clock_ready_o = clk_byte[4];
   assign clk_en_o      = clk_byte[3:2];
   assign clk_sel_o     = clk_byte[1:0];

   assign ser_enable_o  = ser_byte[3];
   assign ser_prbsen_o  = ser_byte[2];
   assign ser_loopen_o  = ser_byte[1];
   assign ser_rx_en_o   = ser_byte[0];

   assign adc_oe_a_o    = adc_byte[3];
   assign adc_on_a_o    = adc_byte[2];
   assign adc_oe_b_o    = adc_byte[1];
   assign adc_on_b_o    = adc_byte[0];

   // Register holds reset asserted, pin is active low
   assign phy_resetn_o  = ~phy_reset;

   //////////////////////////////
   // LED source mux
   assign led_hw = {{(`CTRL_BYTE_W-2){1'b0}}, clk_status_i, serdes_link_up_i};

   // Source bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

/* rtl/sim_timer_fsm.sv */
//////////////////////////////
// One-shot and periodic share one counter, last write wins
// A written value of 0 stops the timer
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "radio_ctrl_cfg.svh"

module sim_timer_fsm import radio_ctrl_pkg::*; (
   input  wire       dsp_clk,
   input  wire       wb_rst,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   input  logic      expire_i,
   output logic      load_o,
   output tick_t     load_val_o,
   output logic      onetime_int_o,
   output logic      periodic_int_o
);

   timer_state_e state;
   // Period minus one, the reload cycle itself counts as one tick
   tick_t        reload_q;
   // Period of 1 pulses every cycle without the counter
   logic         every_cycle_q;
   logic         wr_oneshot;
   logic         wr_periodic;
   logic         timer_wr;
   logic         reload;

   assign wr_oneshot  = set_stb_i && (set_addr_i == set_addr_t'(`SR_SIMTIMER));
   assign wr_periodic = set_stb_i && (set_addr_i == set_addr_t'(`SR_SIMTIMER + 1));
   assign timer_wr    = wr_oneshot || wr_periodic;

   // Restart the count in the expiry cycle
   assign reload = (state == TIMER_PERIODIC) && expire_i && (reload_q != '0);

   //////////////////////////////
   // Counter load, software write has priority
   assign load_o     = timer_wr || reload;
   assign load_val_o = timer_wr ? tick_t'(set_data_i) : reload_q;

   // Expiry pulse gated by mode, no extra delay
   assign onetime_int_o  = (state == TIMER_ONESHOT) && expire_i;
   assign periodic_int_o = (state == TIMER_PERIODIC) && (expire_i || every_cycle_q);

   //////////////////////////////
   // Mode FSM
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         state         <= TIMER_IDLE;
         reload_q      <= '0;
         every_cycle_q <= 1'b0;
      end else if (timer_wr) begin
         // New write cancels whatever is pending
         every_cycle_q <= 1'b0;
         if (set_data_i == '0) begin
            state <= TIMER_IDLE;
         end else if (wr_oneshot) begin
            state <= TIMER_ONESHOT;
         end else begin
            state    <= TIMER_PERIODIC;
            reload_q <= tick_t'(set_data_i) - tick_t'(1);
         end
      end else if (expire_i) begin
         case (state)
            TIMER_ONESHOT: begin
               state <= TIMER_IDLE;
            end
            TIMER_PERIODIC: begin
               if (reload_q == '0) begin
                  every_cycle_q <= 1'b1;
               end
            end
            default: begin
               state <= TIMER_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/radio_ctrl_top.sv */
//////////////////////////////
// Single clock domain, synchronous reset
// Settings writes take effect one cycle after the strobe
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_top import radio_ctrl_pkg::*; (
   input  wire        dsp_clk,
   input  wire        wb_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   output logic       clock_ready_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic       ser_enable_o,
   output logic       ser_prbsen_o,
   output logic       ser_loopen_o,
   output logic       ser_rx_en_o,
   output logic       adc_oe_a_o,
   output logic       adc_on_a_o,
   output logic       adc_oe_b_o,
   output logic       adc_on_b_o,
   output logic       phy_resetn_o,
   output ctrl_byte_t leds_o,
   output logic       onetime_int_o,
   output logic       periodic_int_o
);

   logic  timer_load;
   tick_t timer_load_val;
   logic  timer_expire;

   //////////////////////////////
   // Front-end control registers
   front_end_regs front_end_regs_i (
      .dsp_clk          (dsp_clk),
      .wb_rst           (wb_rst),
      .set_stb_i        (set_stb_i),
      .set_addr_i       (set_addr_i),
      .set_data_i       (set_data_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .clock_ready_o    (clock_ready_o),
      .clk_en_o         (clk_en_o),
      .clk_sel_o        (clk_sel_o),
      .ser_enable_o     (ser_enable_o),
      .ser_prbsen_o     (ser_prbsen_o),
      .ser_loopen_o     (ser_loopen_o),
      .ser_rx_en_o      (ser_rx_en_o),
      .adc_oe_a_o       (adc_oe_a_o),
      .adc_on_a_o       (adc_on_a_o),
      .adc_oe_b_o       (adc_oe_b_o),
      .adc_on_b_o       (adc_on_b_o),
      .phy_resetn_o     (phy_resetn_o),
      .leds_o           (leds_o)
   );

   //////////////////////////////
   // Simple timer
   sim_timer_fsm sim_timer_fsm_i (
      .dsp_clk        (dsp_clk),
      .wb_rst         (wb_rst),
      .set_stb_i      (set_stb_i),
      .set_addr_i     (set_addr_i),
      .set_data_i     (set_data_i),
      .expire_i       (timer_expire),
      .load_o         (timer_load),
      .load_val_o     (timer_load_val),
      .onetime_int_o  (onetime_int_o),
      .periodic_int_o (periodic_int_o)
   );

   tick_counter tick_counter_i (
      .dsp_clk    (dsp_clk),
      .wb_rst     (wb_rst),
      .load_i     (timer_load),
      .load_val_i (timer_load_val),
      .expire_o   (timer_expire)
   );

endmodule

`default_nettype wire

/* tests/radio_ctrl_asserts.sv */
//////////////////////////////
// Bound to radio_ctrl_top, sees its ports only
// Timer checks track writes to 198 and 199
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "radio_ctrl_cfg.svh"

module radio_ctrl_asserts import radio_ctrl_pkg::*; (
   input wire        dsp_clk,
   input wire        wb_rst,
   input logic       set_stb_i,
   input set_addr_t  set_addr_i,
   input set_data_t  set_data_i,
   input logic       clk_status_i,
   input logic       serdes_link_up_i,
   input logic       clock_ready_o,
   input logic [1:0] clk_en_o,
   input logic [1:0] clk_sel_o,
   input logic       ser_enable_o,
   input logic       ser_prbsen_o,
   input logic       ser_loopen_o,
   input logic       ser_rx_en_o,
   input logic       adc_oe_a_o,
   input logic       adc_on_a_o,
   input logic       adc_oe_b_o,
   input logic       adc_on_b_o,
   input logic       phy_resetn_o,
   input ctrl_byte_t leds_o,
   input logic       onetime_int_o,
   input logic       periodic_int_o
);

   ctrl_byte_t led_sw_m;
   ctrl_byte_t led_src_m;
   ctrl_byte_t led_hw;
   tick_t      ot_left;
   tick_t      pr_left;
   tick_t      pr_n;
   logic       exp_ot;
   logic       exp_pr;
   logic       ctrl_wr;
   logic       timer_wr;
   int         fail_cnt = 0;

   // Each LED bit follows hardware where its source bit is set
   function automatic ctrl_byte_t led_expect(input ctrl_byte_t src, input ctrl_byte_t hw,
                                             input ctrl_byte_t sw);
      ctrl_byte_t leds;
      for (int b = 0; b < `CTRL_BYTE_W; b++) begin
         leds[b] = src[b] ? hw[b] : sw[b];
      end
      return leds;
   endfunction

   assign ctrl_wr  = set_stb_i && (set_addr_i inside {set_addr_t'(`SR_CLK),
                     set_addr_t'(`SR_SER), set_addr_t'(`SR_ADC), set_addr_t'(`SR_LED),
                     set_addr_t'(`SR_PHY), set_addr_t'(`SR_LED_SRC)});
   assign timer_wr = set_stb_i && ((set_addr_i == set_addr_t'(`SR_SIMTIMER)) ||
                     (set_addr_i == set_addr_t'(`SR_SIMTIMER + 1)));
   assign led_hw   = {{(`CTRL_BYTE_W-2){1'b0}}, clk_status_i, serdes_link_up_i};

   //////////////////////////////
   // Expected LED bytes and timer schedule
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         led_sw_m  <= '0;
         led_src_m <= '0;
         ot_left   <= '0;
         pr_left   <= '0;
         pr_n      <= '0;
         exp_ot    <= 1'b0;
         exp_pr    <= 1'b0;
      end else begin
         if (set_stb_i && (set_addr_i == set_addr_t'(`SR_LED))) begin
            led_sw_m <= set_data_i[7:0];
         end
         if (set_stb_i && (set_addr_i == set_addr_t'(`SR_LED_SRC))) begin
            led_src_m <= set_data_i[7:0];
         end
         if (timer_wr) begin
            // Any timer write cancels the pending schedule
            ot_left <= (set_addr_i == set_addr_t'(`SR_SIMTIMER)) ? set_data_i : '0;
            pr_left <= (set_addr_i == set_addr_t'(`SR_SIMTIMER + 1)) ? set_data_i : '0;
            pr_n    <= (set_addr_i == set_addr_t'(`SR_SIMTIMER + 1)) ? set_data_i : '0;
            exp_ot  <= 1'b0;
            exp_pr  <= 1'b0;
         end else begin
            exp_ot <= (ot_left == tick_t'(1));
            if (ot_left != '0) begin
               ot_left <= ot_left - tick_t'(1);
            end
            exp_pr <= (pr_left == tick_t'(1));
            if (pr_left == tick_t'(1)) begin
               pr_left <= pr_n;
            end else if (pr_left != '0) begin
               pr_left <= pr_left - tick_t'(1);
            end
         end
      end
   end

   //////////////////////////////
   // Properties
   a_reset: assert property (@(posedge dsp_clk) wb_rst |=>
      (!clock_ready_o && clk_en_o == 2'b00 && clk_sel_o == 2'b00 && !ser_enable_o &&
       !ser_prbsen_o && !ser_loopen_o && !ser_rx_en_o && !adc_oe_a_o && !adc_on_a_o &&
       !adc_oe_b_o && !adc_on_b_o && phy_resetn_o && leds_o == '0 &&
       !onetime_int_o && !periodic_int_o))
      else begin
         fail_cnt++;
         $error("reset values wrong");
      end

   a_clk_wr: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      set_stb_i && set_addr_i == set_addr_t'(`SR_CLK) |=>
      {clock_ready_o, clk_en_o, clk_sel_o} == $past(set_data_i[4:0]))
      else begin
         fail_cnt++;
         $error("clock byte not mapped");
      end

   a_ser_wr: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      set_stb_i && set_addr_i == set_addr_t'(`SR_SER) |=>
      {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} == $past(set_data_i[3:0]))
      else begin
         fail_cnt++;
         $error("SERDES byte not mapped");
      end

   a_adc_wr: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      set_stb_i && set_addr_i == set_addr_t'(`SR_ADC) |=>
      {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} == $past(set_data_i[3:0]))
      else begin
         fail_cnt++;
         $error("ADC byte not mapped");
      end

   a_phy_wr: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      set_stb_i && set_addr_i == set_addr_t'(`SR_PHY) |=>
      phy_resetn_o == !$past(set_data_i[0]))
      else begin
         fail_cnt++;
         $error("PHY reset bit not mapped");
      end

   a_hold: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      !ctrl_wr |=> $stable({clock_ready_o, clk_en_o, clk_sel_o,
      ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o, adc_oe_a_o, adc_on_a_o,
      adc_oe_b_o, adc_on_b_o, phy_resetn_o}))
      else begin
         fail_cnt++;
         $error("control output changed without a write");
      end

   a_leds: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      leds_o == led_expect(led_src_m, led_hw, led_sw_m))
      else begin
         fail_cnt++;
         $error("CHECK FAILED at %0t: leds_o got 0x%0h, expected 0x%0h", $time,
                $sampled(leds_o),
                led_expect($sampled(led_src_m), $sampled(led_hw), $sampled(led_sw_m)));
      end

   a_oneshot: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      onetime_int_o == exp_ot)
      else begin
         fail_cnt++;
         $error("CHECK FAILED at %0t: onetime_int_o got %0b, expected %0b", $time,
                $sampled(onetime_int_o), $sampled(exp_ot));
      end

   a_periodic: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      periodic_int_o == exp_pr)
      else begin
         fail_cnt++;
         $error("CHECK FAILED at %0t: periodic_int_o got %0b, expected %0b", $time,
                $sampled(periodic_int_o), $sampled(exp_pr));
      end

endmodule

bind radio_ctrl_top radio_ctrl_asserts radio_ctrl_asserts_i (.*);

`default_nettype wire

/* tests/radio_ctrl_tb.sv */
//////////////////////////////
// Drives settings writes on the rising edge, samples on the falling edge
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "radio_ctrl_cfg.svh"

module radio_ctrl_tb import radio_ctrl_pkg::*; ();

   // Largest timer value written, and cycles per settings write
   localparam int MAX_N           = 17;
   localparam int WR_CYCLES       = 2;
   localparam int RESET_CYCLES    = 4 + 2;
   localparam int REG_CYCLES      = 7 * WR_CYCLES;
   localparam int LED_CYCLES      = 8 * (2 * WR_CYCLES + 1);
   localparam int ONESHOT_CYCLES  = 2 * WR_CYCLES + (MAX_N + 6) + 6;
   localparam int PERIODIC_CYCLES = 4 * WR_CYCLES + (4 * MAX_N + 2) + (2 * MAX_N + 4) + 6 +
                                    (MAX_N + 6);
   localparam int RUN_CYCLES      = RESET_CYCLES + REG_CYCLES + LED_CYCLES +
                                    ONESHOT_CYCLES + PERIODIC_CYCLES;
   localparam int MARGIN          = 100;

   logic       dsp_clk;
   logic       wb_rst;
   logic       set_stb_i;
   set_addr_t  set_addr_i;
   set_data_t  set_data_i;
   logic       clk_status_i;
   logic       serdes_link_up_i;
   logic       clock_ready_o;
   logic [1:0] clk_en_o;
   logic [1:0] clk_sel_o;
   logic       ser_enable_o;
   logic       ser_prbsen_o;
   logic       ser_loopen_o;
   logic       ser_rx_en_o;
   logic       adc_oe_a_o;
   logic       adc_on_a_o;
   logic       adc_oe_b_o;
   logic       adc_on_b_o;
   logic       phy_resetn_o;
   ctrl_byte_t leds_o;
   logic       onetime_int_o;
   logic       periodic_int_o;

   int          seed;
   int          tb_errors;
   int          checks;
   int          test_base;
   int          assert_base;
   ctrl_byte_t  exp_clk;
   ctrl_byte_t  exp_ser;
   ctrl_byte_t  exp_adc;
   ctrl_byte_t  exp_led;
   ctrl_byte_t  exp_src;
   logic        exp_phy;
   logic [31:0] rnd;
   int          n;

   radio_ctrl_top radio_ctrl_top_i (.*);

   initial begin
      dsp_clk = 1'b0;
      forever #5 dsp_clk = ~dsp_clk;
   end

   // Watchdog
   initial begin
      #((RUN_CYCLES + MARGIN) * 10);
      $display("Watchdog timeout: the tests did not finish in time");
      $display("ERRORS FOUND");
      $finish;
   end

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         tb_errors++;
         $display("CHECK FAILED at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   // LED bit from hardware where the source bit is set, else from software
   function automatic ctrl_byte_t mux_leds(input ctrl_byte_t src, input ctrl_byte_t hw,
                                           input ctrl_byte_t sw);
      ctrl_byte_t leds;
      for (int b = 0; b < 8; b++) begin
         if (src[b]) begin
            leds[b] = hw[b];
         end else begin
            leds[b] = sw[b];
         end
      end
      return leds;
   endfunction

   // Write lands at the second edge, returns at the following falling edge
   task automatic write_set(input int addr, input logic [31:0] data);
      @(posedge dsp_clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= set_addr_t'(addr);
      set_data_i <= data;
      @(posedge dsp_clk);
      set_stb_i  <= 1'b0;
      @(negedge dsp_clk);
   endtask

   task automatic check_regs();
      ctrl_byte_t hw;
      hw = {6'b0, clk_status_i, serdes_link_up_i};
      check_val("clock_ready_o", 32'(clock_ready_o), 32'(exp_clk[4]));
      check_val("clk_en_o", 32'(clk_en_o), 32'(exp_clk[3:2]));
      check_val("clk_sel_o", 32'(clk_sel_o), 32'(exp_clk[1:0]));
      check_val("ser_bits", 32'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}),
                32'(exp_ser[3:0]));
      check_val("adc_bits", 32'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}),
                32'(exp_adc[3:0]));
      check_val("phy_resetn_o", 32'(phy_resetn_o), 32'(!exp_phy));
      check_val("leds_o", 32'(leds_o), 32'(mux_leds(exp_src, hw, exp_led)));
   endtask

   // Cycle j counts from the write edge
   task automatic watch_timer(input int n_ot, input int n_pr, input int cycles);
      for (int j = 0; j < cycles; j++) begin
         check_val("onetime_int_o", 32'(onetime_int_o), 32'(n_ot > 0 && j == n_ot));
         check_val("periodic_int_o", 32'(periodic_int_o),
                   32'(n_pr > 0 && j > 0 && (j % n_pr) == 0));
         @(negedge dsp_clk);
      end
   endtask

   task automatic end_test(input string name);
      int asserts_now;
      asserts_now = radio_ctrl_top_i.radio_ctrl_asserts_i.fail_cnt;
      $display("Test %s finished with %0d failed checks and %0d assertion failures", name,
               tb_errors - test_base, asserts_now - assert_base);
      test_base   = tb_errors;
      assert_base = asserts_now;
   endtask

   initial begin
      int total;
      seed = 79;
      tb_errors = 0;
      checks = 0;
      test_base = 0;
      assert_base = 0;
      {exp_clk, exp_ser, exp_adc, exp_led, exp_src, exp_phy} = '0;
      wb_rst = 1'b1;
      set_stb_i = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      clk_status_i = 1'b0;
      serdes_link_up_i = 1'b0;
      repeat (3) @(posedge dsp_clk);
      wb_rst <= 1'b0;
      @(negedge dsp_clk);

      check_regs();
      watch_timer(0, 0, 2);
      end_test("reset_values");

      ////////////////////////////// Register writes
      rnd = $random(seed);
      write_set(`SR_CLK, rnd);
      exp_clk = rnd[7:0];
      check_regs();
      rnd = $random(seed);
      write_set(`SR_SER, rnd);
      exp_ser = rnd[7:0];
      check_regs();
      rnd = $random(seed);
      write_set(`SR_ADC, rnd);
      exp_adc = rnd[7:0];
      check_regs();
      write_set(`SR_PHY, 32'h1);
      exp_phy = 1'b1;
      check_regs();
      write_set(5, $random(seed));
      write_set(7, $random(seed));
      write_set(200, $random(seed));
      check_regs();
      end_test("register_writes");

      ////////////////////////////// LED source mux
      for (int i = 0; i < 8; i++) begin
         rnd = $random(seed);
         write_set(`SR_LED, rnd);
         exp_led = rnd[7:0];
         rnd = $random(seed);
         write_set(`SR_LED_SRC, rnd);
         exp_src = rnd[7:0];
         rnd = $random(seed);
         @(posedge dsp_clk);
         clk_status_i     <= rnd[0];
         serdes_link_up_i <= rnd[1];
         @(negedge dsp_clk);
         check_regs();
      end
      end_test("led_mux");

      ////////////////////////////// One-shot
      rnd = $random(seed);
      n = int'(rnd[3:0]) + 1;
      write_set(`SR_SIMTIMER, n);
      watch_timer(n, 0, n + 6);
      write_set(`SR_SIMTIMER, 1);
      watch_timer(1, 0, 6);
      end_test("oneshot");

      ////////////////////////////// Periodic, stop and replace
      rnd = $random(seed);
      n = int'(rnd[3:0]) + 2;
      write_set(`SR_SIMTIMER + 1, n);
      watch_timer(0, n, 4 * n + 2);
      write_set(`SR_SIMTIMER + 1, 0);
      watch_timer(0, 0, 2 * n + 4);
      write_set(`SR_SIMTIMER + 1, 1);
      watch_timer(0, 1, 6);
      rnd = $random(seed);
      n = int'(rnd[3:0]) + 1;
      write_set(`SR_SIMTIMER, n);
      watch_timer(n, 0, n + 6);
      end_test("periodic_stop");

      total = tb_errors + radio_ctrl_top_i.radio_ctrl_asserts_i.fail_cnt;
      $display("Checks: %0d, failed checks: %0d, assertion failures: %0d",
               checks, tb_errors, radio_ctrl_top_i.radio_ctrl_asserts_i.fail_cnt);
      if (total == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* radio_ctrl_top.f */
+incdir+rtl
rtl/radio_ctrl_pkg.sv
rtl/tick_counter.sv
rtl/front_end_regs.sv
rtl/sim_timer_fsm.sv
rtl/radio_ctrl_top.sv
tests/radio_ctrl_asserts.sv
tests/radio_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the control-plane testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
BIN=radio_ctrl_sim

verilator --binary --timing --assert \
   -f radio_ctrl_top.f \
   --top-module radio_ctrl_tb \
   -Mdir "$BUILD_DIR" -o "$BIN"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
   echo "Simulation failed"
   exit 1
fi

echo "Simulation passed"
exit 0
